// ==== riscboy_fabric.f ====
src/bus_pkg.sv
src/soc_map_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/sram_slave.sv
src/gpio_regs.sv
src/scanline_fetch.sv
src/riscboy_fabric.sv
verification/tb_riscboy_fabric.sv

// ==== Makefile ====
# Verilator build and run of the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_riscboy_fabric
FILELIST  ?= riscboy_fabric.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_riscboy_fabric.sv ====
// ==============================
// Bus fabric testbench
// Host traffic, GPIO, unmapped access
// and line fetch under contention
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_riscboy_fabric;

localparam int SRAM_WORDS = 1024;
localparam int N_PADS     = 11;
localparam int LINE_WORDS = 16;
localparam int TIMEOUT    = 200;   // Cycles allowed per wait

logic                       clk = 1'b0;
logic                       rst_n;
bus_pkg::bus_req_t          host_req;
logic                       host_vld;
bus_pkg::bus_rsp_t          host_rsp;
logic                       host_rsp_vld;
logic                       line_start;
logic [bus_pkg::W_ADDR-1:0] line_base;
logic [bus_pkg::W_DATA-1:0] pix_data;
logic                       pix_vld;
logic                       line_done;
logic [N_PADS-1:0]          padout;
logic [N_PADS-1:0]          padoe;
logic [N_PADS-1:0]          padin;

// Reference model and expectations
logic [31:0]       model [SRAM_WORDS];
logic [N_PADS-1:0] exp_padout;
logic [N_PADS-1:0] exp_padoe;
logic [31:0]       exp_rdata;
logic              exp_err;
logic              chk_rdata;   // Read data compared on this response
logic [31:0]       exp_pix;
logic              line_active;
int                pix_cnt;
int                errors;
int                timeouts;

riscboy_fabric #(
	.SRAM_WORDS (SRAM_WORDS),
	.N_PADS     (N_PADS),
	.LINE_WORDS (LINE_WORDS)
) uut (
	.clk_sys      (clk),
	.rst_n        (rst_n),
	.host_req     (host_req),
	.host_vld     (host_vld),
	.host_rsp     (host_rsp),
	.host_rsp_vld (host_rsp_vld),
	.line_start   (line_start),
	.line_base    (line_base),
	.pix_data     (pix_data),
	.pix_vld      (pix_vld),
	.line_done    (line_done),
	.padout       (padout),
	.padoe        (padoe),
	.padin        (padin)
);

always #5 clk = ~clk;

wire host_grant = uut.bus_accept && !uut.fetch_vld;   // Host won the idle bus

function automatic int word_idx(input logic [31:0] addr);
	return int'((addr >> 2) % SRAM_WORDS);
endfunction

function automatic logic [31:0] fill_word(input int idx);
	logic [31:0] a;
	a = 32'(idx) << 2;
	return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
endfunction

// Pixel words counted per line
always @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		line_active <= 1'b0;
		pix_cnt <= 0;
	end else if (line_start) begin
		line_active <= 1'b1;
		pix_cnt <= 0;
	end else begin
		if (pix_vld)
			pix_cnt <= pix_cnt + 1;
		if (line_done)
			line_active <= 1'b0;
	end
end

always_comb exp_pix = model[word_idx(line_base + (32'(pix_cnt) << 2))];

// ==============================
// Protocol and data checks
// ==============================
a_grant_latency: assert property (@(posedge clk) disable iff (!rst_n)
	host_grant |=> host_rsp_vld)
	else begin
		errors++;
		$display("ERROR t=%0t host response missing one cycle after the grant", $time);
	end

a_host_pending: assert property (@(posedge clk) disable iff (!rst_n)
	host_rsp_vld |-> host_vld)
	else begin
		errors++;
		$display("ERROR t=%0t host response strobe without a host request", $time);
	end

a_fetch_pending: assert property (@(posedge clk) disable iff (!rst_n)
	uut.fetch_rsp_vld |-> uut.fetch_vld)
	else begin
		errors++;
		$display("ERROR t=%0t fetch response strobe without a fetch request", $time);
	end

a_host_err: assert property (@(posedge clk) disable iff (!rst_n)
	host_rsp_vld |-> host_rsp.err == exp_err)
	else begin
		errors++;
		$display("MISMATCH t=%0t host_rsp.err exp=%b got=%b", $time, exp_err,
			$sampled(host_rsp.err));
	end

a_host_rdata: assert property (@(posedge clk) disable iff (!rst_n)
	host_rsp_vld && chk_rdata |-> host_rsp.rdata == exp_rdata)
	else begin
		errors++;
		$display("MISMATCH t=%0t host_rsp.rdata exp=%h got=%h", $time, exp_rdata,
			$sampled(host_rsp.rdata));
	end

a_padout: assert property (@(posedge clk) disable iff (!rst_n)
	host_rsp_vld |-> padout == exp_padout)
	else begin
		errors++;
		$display("MISMATCH t=%0t padout exp=%h got=%h", $time, exp_padout, $sampled(padout));
	end

a_padoe: assert property (@(posedge clk) disable iff (!rst_n)
	host_rsp_vld |-> padoe == exp_padoe)
	else begin
		errors++;
		$display("MISMATCH t=%0t padoe exp=%h got=%h", $time, exp_padoe, $sampled(padoe));
	end

a_pix_pending: assert property (@(posedge clk) disable iff (!rst_n)
	pix_vld |-> line_active && pix_cnt < LINE_WORDS)
	else begin
		errors++;
		$display("ERROR t=%0t pixel word outside a line or beyond its length", $time);
	end

a_pix_data: assert property (@(posedge clk) disable iff (!rst_n)
	pix_vld |-> pix_data == exp_pix)
	else begin
		errors++;
		$display("MISMATCH t=%0t pix_data exp=%h got=%h", $time, exp_pix, $sampled(pix_data));
	end

a_line_done: assert property (@(posedge clk) disable iff (!rst_n)
	line_done == (pix_vld && pix_cnt == LINE_WORDS - 1))
	else begin
		errors++;
		$display("ERROR t=%0t line_done not aligned with the last pixel word", $time);
	end

// ==============================
// Host port tasks
// ==============================
task automatic host_xfer(input logic [31:0] addr, input logic write,
		input logic [31:0] wdata, input logic [3:0] be);
	int  n;
	logic got;
	host_req = '{addr: addr, write: write, wdata: wdata, be: be};
	host_vld = 1'b1;
	got = 1'b0;
	for (n = 0; n < TIMEOUT && !got; n++) begin
		@(negedge clk);
		got = host_rsp_vld;
	end
	@(posedge clk);
	#1;
	host_vld = 1'b0;   // Dropped after the response edge
	if (!got) begin
		timeouts++;
		$display("ERROR t=%0t no host response within %0d cycles", $time, TIMEOUT);
	end
endtask

task automatic sram_write(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] be);
	int i;
	int b;
	i = word_idx(addr);
	for (b = 0; b < 4; b++)
		if (be[b])
			model[i][b*8 +: 8] = wdata[b*8 +: 8];
	chk_rdata = 1'b0;
	exp_err = 1'b0;
	host_xfer(addr, 1'b1, wdata, be);
endtask

task automatic sram_read(input logic [31:0] addr);
	exp_rdata = model[word_idx(addr)];
	chk_rdata = 1'b1;
	exp_err = 1'b0;
	host_xfer(addr, 1'b0, '0, 4'hF);
endtask

task automatic gpio_xfer(input logic write, input logic [3:0] ofs, input logic [31:0] wdata);
	logic [31:0] addr;
	addr = soc_map_pkg::GPIO_BASE | ($urandom & ~soc_map_pkg::GPIO_MASK & 32'hFFFF_FFF0)
		| {28'h0, ofs};
	if (write && ofs == soc_map_pkg::GPIO_OUT_OFS)
		exp_padout = wdata[N_PADS-1:0];
	if (write && ofs == soc_map_pkg::GPIO_OE_OFS)
		exp_padoe = wdata[N_PADS-1:0];
	case (ofs)
		soc_map_pkg::GPIO_OUT_OFS: exp_rdata = 32'(exp_padout);
		soc_map_pkg::GPIO_OE_OFS:  exp_rdata = 32'(exp_padoe);
		soc_map_pkg::GPIO_IN_OFS:  exp_rdata = 32'(padin);
		default:                   exp_rdata = '0;   // Spare offset
	endcase
	chk_rdata = !write;
	exp_err = 1'b0;
	host_xfer(addr, write, wdata, 4'hF);
endtask

task automatic unmapped_xfer(input logic [31:0] addr, input logic write);
	chk_rdata = 1'b1;
	exp_rdata = '0;
	exp_err = 1'b1;
	host_xfer(addr, write, $urandom, 4'hF);
endtask

function automatic logic [31:0] sram_addr();
	return $urandom & ~soc_map_pkg::SRAM_MASK & 32'hFFFF_FFFC;
endfunction

task automatic run_line(input logic [31:0] base);
	int  n;
	logic got;
	line_base = base;
	line_start = 1'b1;
	@(posedge clk);
	#1;
	line_start = 1'b0;
	got = 1'b0;
	for (n = 0; n < TIMEOUT && !got; n++) begin
		@(negedge clk);
		got = line_done;
	end
	@(posedge clk);
	#1;
	if (!got) begin
		timeouts++;
		$display("ERROR t=%0t line fetch did not finish within %0d cycles", $time, TIMEOUT);
	end
endtask

// Writes stay in the upper half clear of the fetched line
task automatic host_traffic(input int count);
	int k;
	logic [31:0] addr;
	for (k = 0; k < count; k++) begin
		if ($urandom_range(1) == 0) begin
			addr = (sram_addr() & 32'hFFFF_F000) | ((32'd512 + $urandom_range(511)) << 2);
			sram_write(addr, $urandom, 4'($urandom));
		end else
			sram_read(sram_addr());
	end
endtask

// ==============================
// Stimulus
// ==============================
initial begin
	logic [31:0] addr;
	logic [31:0] addrs[$];
	int k;
	void'($urandom(82));
	errors = 0;
	timeouts = 0;
	rst_n = 1'b0;
	host_req = '0;
	host_vld = 1'b0;
	line_start = 1'b0;
	line_base = '0;
	padin = '0;
	exp_padout = '0;
	exp_padoe = '0;
	exp_rdata = '0;
	exp_err = 1'b0;
	chk_rdata = 1'b0;
	repeat (8) @(posedge clk);
	#1;
	rst_n = 1'b1;

	@(negedge clk);
	assert (!host_rsp_vld && !pix_vld && !line_done && padout == '0 && padoe == '0)
		else begin
			errors++;
			$display("ERROR t=%0t outputs not low after reset", $time);
		end
	@(posedge clk);
	#1;

	for (k = 0; k < SRAM_WORDS; k++)
		sram_write(32'(k) << 2, fill_word(k), 4'hF);

	// Random byte-enabled writes then read back
	for (k = 0; k < 40; k++) begin
		addr = sram_addr();
		addrs.push_back(addr);
		sram_write(addr, $urandom, 4'($urandom));
	end
	foreach (addrs[i])
		sram_read(addrs[i]);
	for (k = 0; k < 20; k++)
		sram_read(sram_addr());

	// GPIO registers and pad input
	gpio_xfer(1'b1, soc_map_pkg::GPIO_OUT_OFS, $urandom);
	gpio_xfer(1'b1, soc_map_pkg::GPIO_OE_OFS, $urandom);
	gpio_xfer(1'b0, soc_map_pkg::GPIO_OUT_OFS, '0);
	gpio_xfer(1'b0, soc_map_pkg::GPIO_OE_OFS, '0);
	padin = N_PADS'($urandom);
	repeat (3) @(posedge clk);
	#1;
	gpio_xfer(1'b0, soc_map_pkg::GPIO_IN_OFS, '0);
	gpio_xfer(1'b1, soc_map_pkg::GPIO_IN_OFS, $urandom);   // Read only register
	gpio_xfer(1'b0, soc_map_pkg::GPIO_IN_OFS, '0);
	gpio_xfer(1'b0, 4'hC, '0);

	// Unmapped window then the aliased SRAM word
	addr = ($urandom & ~soc_map_pkg::GPIO_MASK & 32'hFFFF_FFFC) | 32'h0010_0000;
	unmapped_xfer(addr, 1'b1);
	unmapped_xfer(addr, 1'b0);
	sram_read(addr & ~soc_map_pkg::SRAM_MASK);

	run_line(32'h0000_0400);

	fork
		run_line(32'h0008_0600);
		host_traffic(30);
	join

	repeat (5) @(posedge clk);
	$display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
	if (errors == 0 && timeouts == 0)
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

`default_nettype wire

// ==== src/riscboy_fabric.sv ====
// ==============================
// System bus fabric top level
// Host and scanline masters sharing one
// bus to SRAM and GPIO
// ==============================

`timescale 1ns/1ps
`default_nettype none

module riscboy_fabric #(
	parameter int SRAM_WORDS = 1024,
	parameter int N_PADS     = 11,
	parameter int LINE_WORDS = 16
) (
	input  wire                        clk_sys,
	input  wire                        rst_n,

	// Host port, stands in for the processor
	input  wire bus_pkg::bus_req_t     host_req,
	input  wire                        host_vld,
	output bus_pkg::bus_rsp_t          host_rsp,
	output logic                       host_rsp_vld,

	// Scanline stream
	input  wire                        line_start,
	input  wire [bus_pkg::W_ADDR-1:0]  line_base,
	output logic [bus_pkg::W_DATA-1:0] pix_data,
	output logic                       pix_vld,
	output logic                       line_done,

	output logic [N_PADS-1:0]          padout,
	output logic [N_PADS-1:0]          padoe,
	input  wire  [N_PADS-1:0]          padin
);

bus_pkg::bus_req_t fetch_req;
logic              fetch_vld;
bus_pkg::bus_rsp_t fetch_rsp;
logic              fetch_rsp_vld;

bus_pkg::bus_req_t bus_req;
logic              bus_accept;
bus_pkg::bus_rsp_t bus_rsp;
logic              bus_rsp_vld;

logic              sram_sel;
bus_pkg::bus_rsp_t sram_rsp;
logic              sram_rsp_vld;
logic              gpio_sel;
bus_pkg::bus_rsp_t gpio_rsp;
logic              gpio_rsp_vld;

// ==============================
// Masters and arbitration
// ==============================

scanline_fetch #(
	.LINE_WORDS (LINE_WORDS)
) fetch_u (
	.clk        (clk_sys),
	.rst_n      (rst_n),
	.line_start (line_start),
	.line_base  (line_base),
	.req        (fetch_req),
	.vld        (fetch_vld),
	.rsp        (fetch_rsp),
	.rsp_vld    (fetch_rsp_vld),
	.pix_data   (pix_data),
	.pix_vld    (pix_vld),
	.line_done  (line_done)
);

bus_arbiter arbiter_u (
	.clk           (clk_sys),
	.rst_n         (rst_n),
	.fetch_req     (fetch_req),    // Index 0, has priority
	.fetch_vld     (fetch_vld),
	.fetch_rsp     (fetch_rsp),
	.fetch_rsp_vld (fetch_rsp_vld),
	.host_req      (host_req),
	.host_vld      (host_vld),
	.host_rsp      (host_rsp),
	.host_rsp_vld  (host_rsp_vld),
	.bus_req       (bus_req),
	.bus_accept    (bus_accept),
	.bus_rsp       (bus_rsp),
	.bus_rsp_vld   (bus_rsp_vld)
);

// ==============================
// Decode and slaves
// ==============================

bus_decoder decoder_u (
	.clk          (clk_sys),
	.rst_n        (rst_n),
	.bus_req      (bus_req),
	.bus_accept   (bus_accept),
	.bus_rsp      (bus_rsp),
	.bus_rsp_vld  (bus_rsp_vld),
	.sram_sel     (sram_sel),
	.sram_rsp     (sram_rsp),
	.sram_rsp_vld (sram_rsp_vld),
	.gpio_sel     (gpio_sel),
	.gpio_rsp     (gpio_rsp),
	.gpio_rsp_vld (gpio_rsp_vld)
);

sram_slave #(
	.SRAM_WORDS (SRAM_WORDS)
) sram_u (
	.clk     (clk_sys),
	.rst_n   (rst_n),
	.req     (bus_req),
	.sel     (sram_sel),
	.rsp     (sram_rsp),
	.rsp_vld (sram_rsp_vld)
);

gpio_regs #(
	.N_PADS (N_PADS)
) gpio_u (
	.clk     (clk_sys),
	.rst_n   (rst_n),
	.req     (bus_req),
	.sel     (gpio_sel),
	.rsp     (gpio_rsp),
	.rsp_vld (gpio_rsp_vld),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin)
);

endmodule

`default_nettype wire

// ==== src/scanline_fetch.sv ====
// ==============================
// Scanline fetch master
// Reads one line of words in address
// order and streams them as pixel words
// ==============================

`timescale 1ns/1ps
`default_nettype none

module scanline_fetch #(
	parameter int LINE_WORDS = 16
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        line_start,
	input  wire [bus_pkg::W_ADDR-1:0]  line_base,

	output bus_pkg::bus_req_t          req,
	output logic                       vld,
	input  wire bus_pkg::bus_rsp_t     rsp,
	input  wire                        rsp_vld,

	output logic [bus_pkg::W_DATA-1:0] pix_data,
	output logic                       pix_vld,
	output logic                       line_done
);

localparam int W_CNT = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

typedef enum logic {
	S_IDLE  = 1'b0,
	S_FETCH = 1'b1
} state_t;

state_t state;
logic [W_CNT-1:0] word_cnt;
logic [bus_pkg::W_ADDR-1:0] addr_q;

wire last_word = word_cnt == W_CNT'(LINE_WORDS - 1);

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= S_IDLE;
		word_cnt <= '0;
		addr_q <= '0;
		pix_vld <= 1'b0;
		line_done <= 1'b0;
	end else begin
		pix_vld <= 1'b0;
		line_done <= 1'b0;
		case (state)
			S_IDLE: if (line_start) begin
				state <= S_FETCH;
				word_cnt <= '0;
				addr_q <= {line_base[bus_pkg::W_ADDR-1:2], 2'b00};   // Force word alignment
			end
			S_FETCH: if (rsp_vld) begin
				pix_vld <= 1'b1;
				addr_q <= addr_q + bus_pkg::W_ADDR'(4);
				word_cnt <= word_cnt + 1'b1;
				if (last_word) begin
					line_done <= 1'b1;
					state <= S_IDLE;
				end
			end
		endcase
	end
end

always_ff @(posedge clk) begin
	if (state == S_FETCH && rsp_vld)
		pix_data <= rsp.rdata;
end

// Read only, one request held per word
assign vld = state == S_FETCH;
assign req = '{addr: addr_q, write: 1'b0, wdata: '0, be: '1};

endmodule

`default_nettype wire

// ==== src/gpio_regs.sv ====
// ==============================
// GPIO register block
// Output and output-enable registers,
// synchronized pad inputs
// ==============================

`timescale 1ns/1ps
`default_nettype none

module gpio_regs #(
	parameter int N_PADS = 11
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire bus_pkg::bus_req_t req,
	input  wire                    sel,
	output bus_pkg::bus_rsp_t      rsp,
	output logic                   rsp_vld,

	output logic [N_PADS-1:0]      padout,
	output logic [N_PADS-1:0]      padoe,
	input  wire  [N_PADS-1:0]      padin
);

logic [N_PADS-1:0] in_meta;
logic [N_PADS-1:0] in_sync;
logic [bus_pkg::W_DATA-1:0] rdata_q;
logic [bus_pkg::W_DATA-1:0] wmask;

wire [1:0] reg_sel = req.addr[3:2];
wire sel_out = reg_sel == soc_map_pkg::GPIO_OUT_OFS[3:2];
wire sel_oe  = reg_sel == soc_map_pkg::GPIO_OE_OFS[3:2];
wire sel_in  = reg_sel == soc_map_pkg::GPIO_IN_OFS[3:2];
wire wen     = sel && req.write;

// Expand byte enables to a bit mask
always_comb begin
	for (int b = 0; b < bus_pkg::W_BE; b++)
		wmask[b*8 +: 8] = {8{req.be[b]}};
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		padout <= '0;
		padoe <= '0;
		in_meta <= '0;
		in_sync <= '0;
		rsp_vld <= 1'b0;
	end else begin
		in_meta <= padin;   // Two-flop synchronizer
		in_sync <= in_meta;
		rsp_vld <= sel;
		if (wen && sel_out)
			padout <= (padout & ~wmask[N_PADS-1:0]) | (req.wdata[N_PADS-1:0] & wmask[N_PADS-1:0]);
		if (wen && sel_oe)
			padoe <= (padoe & ~wmask[N_PADS-1:0]) | (req.wdata[N_PADS-1:0] & wmask[N_PADS-1:0]);
	end
end

// Unused offset reads as zero, never an error
always_ff @(posedge clk) begin
	if (sel) begin
		rdata_q <= '0;
		if (sel_out)
			rdata_q[N_PADS-1:0] <= padout;
		else if (sel_oe)
			rdata_q[N_PADS-1:0] <= padoe;
		else if (sel_in)
			rdata_q[N_PADS-1:0] <= in_sync;
	end
end

assign rsp = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== src/sram_slave.sv ====
// ==============================
// Internal synchronous SRAM
// Word wide, byte-enabled writes,
// response one cycle after select
// ==============================

`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
	parameter int SRAM_WORDS = 1024
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire bus_pkg::bus_req_t req,
	input  wire                    sel,
	output bus_pkg::bus_rsp_t      rsp,
	output logic                   rsp_vld
);

localparam int W_IDX = $clog2(SRAM_WORDS);

logic [bus_pkg::W_DATA-1:0] mem [SRAM_WORDS];
logic [bus_pkg::W_DATA-1:0] rdata_q;

// Word address wraps at the array depth
wire [W_IDX-1:0] idx = req.addr[W_IDX+1:2];

always_ff @(posedge clk) begin
	if (sel) begin
		rdata_q <= mem[idx];   // Old data on a write
		if (req.write) begin
			for (int b = 0; b < bus_pkg::W_BE; b++)
				if (req.be[b])
					mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
		end
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		rsp_vld <= 1'b0;
	else
		rsp_vld <= sel;
end

assign rsp = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== src/bus_decoder.sv ====
// ==============================
// Bus address decoder
// Selects one slave per accepted transfer
// and muxes its response back
// ==============================

`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	input  wire                    clk,
	input  wire                    rst_n,

	input  wire bus_pkg::bus_req_t bus_req,
	input  wire                    bus_accept,
	output bus_pkg::bus_rsp_t      bus_rsp,
	output logic                   bus_rsp_vld,

	output logic                   sram_sel,
	input  wire bus_pkg::bus_rsp_t sram_rsp,
	input  wire                    sram_rsp_vld,

	output logic                   gpio_sel,
	input  wire bus_pkg::bus_rsp_t gpio_rsp,
	input  wire                    gpio_rsp_vld
);

typedef enum logic [1:0] {
	SLV_SRAM = 2'd0,
	SLV_GPIO = 2'd1,
	SLV_NONE = 2'd2
} slave_t;

slave_t slave_q;   // Slave chosen for the outstanding transfer
logic   err_vld;   // Delayed strobe for unmapped addresses

wire hit_sram = (bus_req.addr & soc_map_pkg::SRAM_MASK) == soc_map_pkg::SRAM_BASE;
wire hit_gpio = (bus_req.addr & soc_map_pkg::GPIO_MASK) == soc_map_pkg::GPIO_BASE;

assign sram_sel = bus_accept && hit_sram;
assign gpio_sel = bus_accept && hit_gpio;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		slave_q <= SLV_NONE;
		err_vld <= 1'b0;
	end else begin
		err_vld <= bus_accept && !hit_sram && !hit_gpio;
		if (bus_accept)
			slave_q <= hit_sram ? SLV_SRAM : hit_gpio ? SLV_GPIO : SLV_NONE;
	end
end

// ==============================
// Response mux
// ==============================
always_comb begin
	case (slave_q)
		SLV_SRAM: begin
			bus_rsp = sram_rsp;
			bus_rsp_vld = sram_rsp_vld;
		end
		SLV_GPIO: begin
			bus_rsp = gpio_rsp;
			bus_rsp_vld = gpio_rsp_vld;
		end
		default: begin
			bus_rsp = '{rdata: '0, err: 1'b1};   // Unmapped
			bus_rsp_vld = err_vld;
		end
	endcase
end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
// ==============================
// Fixed-priority bus arbiter
// Grants one transfer at a time, fetch
// master first, and steers the response
// back to the owner
// ==============================

`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire                  clk,
	input  wire                  rst_n,

	input  wire bus_pkg::bus_req_t fetch_req,
	input  wire                  fetch_vld,
	output bus_pkg::bus_rsp_t    fetch_rsp,
	output logic                 fetch_rsp_vld,

	input  wire bus_pkg::bus_req_t host_req,
	input  wire                  host_vld,
	output bus_pkg::bus_rsp_t    host_rsp,
	output logic                 host_rsp_vld,

	output bus_pkg::bus_req_t    bus_req,
	output logic                 bus_accept,
	input  wire bus_pkg::bus_rsp_t bus_rsp,
	input  wire                  bus_rsp_vld
);

logic busy;        // Transfer outstanding
logic owner_host;  // Owner of the outstanding transfer

// Lower master wins, same as the display master in the full system
wire grant_fetch = fetch_vld;
wire grant_host  = host_vld && !fetch_vld;

assign bus_accept = !busy && (grant_fetch || grant_host);
assign bus_req    = grant_fetch ? fetch_req : host_req;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		busy <= 1'b0;
		owner_host <= 1'b0;
	end else if (bus_accept) begin
		busy <= 1'b1;
		owner_host <= grant_host;
	end else if (bus_rsp_vld) begin
		busy <= 1'b0;   // Free again from the next cycle
	end
end

// Payload goes to both, only the owner sees the strobe
assign fetch_rsp     = bus_rsp;
assign host_rsp      = bus_rsp;
assign fetch_rsp_vld = bus_rsp_vld && !owner_host;
assign host_rsp_vld  = bus_rsp_vld && owner_host;

endmodule

`default_nettype wire

// ==== src/soc_map_pkg.sv ====
// ==============================
// System address map
// Partial decode of slave windows and
// GPIO register offsets
// ==============================

`default_nettype none

package soc_map_pkg;

	// Only bits 20:19 take part in decoding
	localparam logic [bus_pkg::W_ADDR-1:0] SRAM_BASE = 32'h0000_0000;
	localparam logic [bus_pkg::W_ADDR-1:0] SRAM_MASK = 32'h0010_0000;   // Low 1 MiB

	// 32'h0010_0000 window (old second SRAM) is unmapped

	localparam logic [bus_pkg::W_ADDR-1:0] GPIO_BASE = 32'h0018_0000;
	localparam logic [bus_pkg::W_ADDR-1:0] GPIO_MASK = 32'h0018_0000;

	// ==============================
	// GPIO registers, selected by addr[3:2]
	// ==============================
	localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
	localparam logic [3:0] GPIO_OE_OFS  = 4'h4;
	localparam logic [3:0] GPIO_IN_OFS  = 4'h8;   // Read only

endpackage

`default_nettype wire

// ==== src/bus_pkg.sv ====
// ==============================
// System bus definitions
// Widths and the request/response
// payloads shared by masters and slaves
// ==============================

`default_nettype none

package bus_pkg;

	localparam int W_ADDR = 32;
	localparam int W_DATA = 32;
	localparam int W_BE   = W_DATA / 8;

	// Held by a master until its response strobe
	typedef struct packed {
		logic [W_ADDR-1:0] addr;
		logic              write;
		logic [W_DATA-1:0] wdata;
		logic [W_BE-1:0]   be;    // One bit per byte lane
	} bus_req_t;

	// Carried alongside a one-cycle response strobe
	typedef struct packed {
		logic [W_DATA-1:0] rdata;
		logic              err;
	} bus_rsp_t;

endpackage

`default_nettype wire
